/* dv/tb_top.sv */
`default_nettype none

module tb_top;

    localparam int LOOP_W   = 11;
    localparam int WAIT_MAX = 40000;   // cycles per wait

    logic                       clk;
    logic                       rstn;
    mcu_pkg::inst_t             inst;
    logic                       inst_valid;
    logic [1:0]                 level;
    mcu_pkg::data_t [3:0]       mem_rd_data;
    mcu_pkg::data_t             macs_result;
    mcu_pkg::data_t             data_encode;
    mcu_pkg::data_t             data_decode;
    mcu_pkg::mem_req_t [3:0]    mem_req;
    mcu_pkg::data_t             mem_wr_data;
    mcu_pkg::data_t             a_data;
    mcu_pkg::data_t             b_data;
    mcu_pkg::data_t             add_data;
    logic                       macs_en;
    logic                       macs_signal;
    logic                       codec_en;
    logic                       finish;
    logic [3:0]                 wen_vec;

    mcu_pkg::data_t  mem [4][4096];
    mcu_pkg::paddr_t ctrl_tab [16];

    // what the instruction in flight should do
    logic            busy;
    logic [1:0]      exp_bank;
    logic [1:0]      c_bank;
    mcu_pkg::addr_t  exp_lo;
    mcu_pkg::data_t  exp_data;
    logic            exp_mac;
    logic            exp_codec;
    logic            exp_sign;
    logic [1:0]      bank_a;
    logic [1:0]      bank_b;
    mcu_pkg::addr_t  lo_a;
    mcu_pkg::addr_t  lo_b;
    int              wr_cnt;
    int              fin_cnt;
    int              err_cnt;
    int              tests_run;
    int              tests_failed;

    mcu_top #(
        .LOOP_W(LOOP_W)
    ) dut_i (
        .clk(clk),
        .rstn(rstn),
        .inst(inst),
        .inst_valid(inst_valid),
        .level(level),
        .mem_rd_data(mem_rd_data),
        .macs_result(macs_result),
        .data_encode(data_encode),
        .data_decode(data_decode),
        .mem_req(mem_req),
        .mem_wr_data(mem_wr_data),
        .a_data(a_data),
        .b_data(b_data),
        .add_data(add_data),
        .macs_en(macs_en),
        .macs_signal(macs_signal),
        .codec_en(codec_en),
        .finish(finish)
    );

    assign wen_vec = {mem_req[3].wen, mem_req[2].wen, mem_req[1].wen, mem_req[0].wen};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // four synchronous banks, one per port
    always @(posedge clk) begin
        for (int p = 0; p < 4; p++) begin
            mem_rd_data[p] <= mem[p][mem_req[p].addr];
            if (mem_req[p].wen)
                mem[p][mem_req[p].addr] <= mem_wr_data;
        end
    end

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("mismatch %s: got %0h expected %0h", name, got, exp);
        err_cnt++;
    endtask

    task automatic note_error(input string msg);
        $display("error: %s", msg);
        err_cnt++;
    endtask

    function automatic mcu_pkg::data_t fill_word(input int p, input int a);
        return {4'(p), 12'(a), 48'h0} ^ (64'(p * 4096 + a) * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    function automatic mcu_pkg::inst_t make_inst(input mcu_pkg::opcode_t op, input int ia,
            input int ib, input int ic, input logic [5:0] imm, input logic b_bank,
            input logic func);
        mcu_pkg::inst_t w;
        w        = '0;
        w.opcode = op;
        w.idx_a  = 4'(ia);
        w.idx_b  = 4'(ib);
        w.idx_c  = 4'(ic);
        w.mode   = imm[5];  // shared top bit
        w.imm_lo = imm[4:0];
        w.b_bank = b_bank;
        w.func   = func;
        return w;
    endfunction

    task automatic load_memories();
        for (int p = 0; p < 4; p++)
            for (int a = 0; a < 4096; a++)
                mem[p][a] = fill_word(p, a);
        for (int i = 0; i < 16; i++) begin
            ctrl_tab[i] = {2'(i % 4), 12'($urandom)};   // bank follows the index
            mem[0][i]   = {$urandom, 18'($urandom), ctrl_tab[i]};
        end
        for (int f = 0; f < 2; f++) begin
            mem[2][8 * f + 0] = 64'h00;
            mem[2][8 * f + 4] = 64'h10;
            mem[2][8 * f + 6] = 64'h20;
        end
    endtask

    // D is the C entry with bank bit 0 flipped, same low bits
    task automatic expect_writes(input int ic, input mcu_pkg::data_t data, input logic mac,
                                 input logic codec, input logic sign);
        c_bank    = ctrl_tab[ic][13:12];
        exp_bank  = c_bank ^ 2'b01;
        exp_lo    = ctrl_tab[ic][11:0];
        exp_data  = data;
        exp_mac   = mac;
        exp_codec = codec;
        exp_sign  = sign;
    endtask

    // mac operands, A and B step with D
    task automatic expect_operands(input int ia, input int ib);
        bank_a = ctrl_tab[ia][13:12];
        lo_a   = ctrl_tab[ia][11:0];
        bank_b = ctrl_tab[ib][13:12];
        lo_b   = ctrl_tab[ib][11:0];
    endtask

    task automatic check_write();
        mcu_pkg::addr_t wa;
        mcu_pkg::addr_t oa;
        mcu_pkg::addr_t ob;
        wa = exp_lo + 12'(wr_cnt);  // C steps with D
        oa = lo_a + 12'(wr_cnt);
        ob = lo_b + 12'(wr_cnt);
        assert (wen_vec == (4'b1 << exp_bank))
            else flag_mismatch("mem_req.wen", wen_vec, 4'b1 << exp_bank);
        assert (mem_req[exp_bank].addr == wa)
            else flag_mismatch("mem_req.addr", mem_req[exp_bank].addr, wa);
        assert (mem_wr_data == exp_data) else flag_mismatch("mem_wr_data", mem_wr_data, exp_data);
        assert (macs_en == exp_mac) else flag_mismatch("macs_en", macs_en, exp_mac);
        assert (codec_en == exp_codec) else flag_mismatch("codec_en", codec_en, exp_codec);
        if (exp_mac) begin
            assert (macs_signal == exp_sign)
                else flag_mismatch("macs_signal", macs_signal, exp_sign);
            assert (add_data == mem[c_bank][wa])
                else flag_mismatch("add_data", add_data, mem[c_bank][wa]);
            assert (a_data == mem[bank_a][oa])
                else flag_mismatch("a_data", a_data, mem[bank_a][oa]);
            assert (b_data == mem[bank_b][ob])
                else flag_mismatch("b_data", b_data, mem[bank_b][ob]);
        end
        wr_cnt++;
    endtask

    always @(negedge clk) begin
        if (rstn && !busy) begin
            assert (wen_vec == 4'b0) else flag_mismatch("mem_req.wen", wen_vec, 0);
            assert (!macs_en) else flag_mismatch("macs_en", macs_en, 0);
            assert (!codec_en) else flag_mismatch("codec_en", codec_en, 0);
            assert (!finish) else note_error("finish pulsed with no instruction running");
        end else if (rstn) begin
            if (wen_vec != 4'b0) begin
                check_write();
            end else begin
                assert (!macs_en) else note_error("macs_en high without a write");
                assert (!codec_en) else note_error("codec_en high without a write");
            end
            if (finish) begin
                fin_cnt++;
                busy = 1'b0;
            end
        end
    end

    task automatic issue_inst(input mcu_pkg::inst_t w);
        logic [11:0] utab_addr;
        utab_addr = 12'({w.func, w.opcode});
        wr_cnt    = 0;
        fin_cnt   = 0;
        repeat (3) @(posedge clk);  // controller back in fetch
        inst       <= w;
        inst_valid <= 1'b1;
        busy = 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (mem_req[0].addr == 12'(w.idx_a))
            else flag_mismatch("mem_req[0].addr", mem_req[0].addr, w.idx_a);
        assert (mem_req[2].addr == utab_addr)
            else flag_mismatch("mem_req[2].addr", mem_req[2].addr, utab_addr);
        @(negedge clk);
        assert (mem_req[0].addr == 12'(w.idx_b))
            else flag_mismatch("mem_req[0].addr", mem_req[0].addr, w.idx_b);
        @(negedge clk);
        assert (mem_req[0].addr == 12'(w.idx_c))
            else flag_mismatch("mem_req[0].addr", mem_req[0].addr, w.idx_c);
    endtask

    task automatic wait_finish(input string name, input int exp_writes);
        int n;
        n = 0;
        while (busy && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            note_error($sformatf("timeout waiting for finish in %s", name));
            busy = 1'b0;
        end
        repeat (4) @(negedge clk);  // a late finish shows up here
        assert (wr_cnt == exp_writes) else flag_mismatch("write count", wr_cnt, exp_writes);
        assert (fin_cnt == 1) else note_error($sformatf("%0d finish pulses seen", fin_cnt));
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (err_cnt == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        int unsigned    seed;
        int             err_start;
        int             n;
        mcu_pkg::data_t d;
        mcu_pkg::inst_t w;
        seed = 52;
        void'($urandom(seed));
        rstn        = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        level       = 2'd0;
        mem_rd_data = '0;
        macs_result = '0;
        data_encode = '0;
        data_decode = '0;
        busy        = 1'b0;
        err_cnt     = 0;
        load_memories();
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        err_start = err_cnt;
        repeat (20) @(negedge clk);
        end_test("reset_quiet", err_start);

        // one clear row through the func=1 table entry
        err_start = err_cnt;
        w = make_inst(mcu_pkg::OP_CLEAR, 3, 7, 12, 6'd1, 1'b1, 1'b1);
        expect_writes(12, '0, 1'b0, 1'b0, 1'b0);
        issue_inst(w);
        wait_finish("decode_order", 8);
        end_test("decode_order", err_start);

        err_start = err_cnt;
        n = 1 + int'($urandom % 8);
        w = make_inst(mcu_pkg::OP_CLEAR, 1, 2, 4, 6'(n), 1'($urandom), 1'b0);
        expect_writes(4, '0, 1'b0, 1'b0, 1'b0);
        issue_inst(w);
        wait_finish("clear", n * 8);
        end_test("clear", err_start);

        err_start = err_cnt;
        d = {$urandom, $urandom};
        @(posedge clk);
        data_encode <= d;
        w = make_inst(mcu_pkg::OP_CODEC, 0, 1, 6, {1'b0, 5'($urandom)}, 1'b0, 1'b0);
        expect_writes(6, d, 1'b0, 1'b1, 1'b0);
        issue_inst(w);
        wait_finish("codec_encode", 16);
        end_test("codec_encode", err_start);

        err_start = err_cnt;
        d = {$urandom, $urandom};
        @(posedge clk);
        data_decode <= d;
        w = make_inst(mcu_pkg::OP_CODEC, 4, 9, 14, {1'b1, 5'($urandom)}, 1'b0, 1'b1);
        expect_writes(14, d, 1'b0, 1'b1, 1'b0);
        issue_inst(w);
        wait_finish("codec_decode", 16);
        end_test("codec_decode", err_start);

        err_start = err_cnt;
        d = {$urandom, $urandom};
        @(posedge clk);
        macs_result <= d;
        level       <= 2'd3;
        w = make_inst(mcu_pkg::OP_MAC, 8, 5, 10, {1'b1, 5'($urandom)}, 1'b0, 1'b0);
        expect_writes(10, d, 1'b1, 1'b0, 1'b1);
        expect_operands(8, 5);
        issue_inst(w);
        wait_finish("mac_level3", 640 * 2 * 4);
        end_test("mac_level3", err_start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* src/agu.sv */
`default_nettype none

module agu (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         load,
    input  wire mcu_pkg::base_addrs_t   bases,
    input  wire [3:0]                   ptr_add,
    input  wire [3:0]                   ptr_clr,
    input  wire [3:0]                   stride,
    output mcu_pkg::paddr_t [3:0]       ptrs
);

    mcu_pkg::paddr_t [3:0] base_arr;

    assign base_arr = {bases.d, bases.c, bases.b, bases.a};   // index 0 is A

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptrs <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (load || ptr_clr[i])
                    ptrs[i] <= base_arr[i];
                else if (ptr_add[i])
                    ptrs[i][11:0] <= ptrs[i][11:0] + 12'(stride);   // bank stays
            end
        end
    end

endmodule

`default_nettype wire

/* src/inst_decoder.sv */
`default_nettype none

module inst_decoder #(
    parameter int LOOP_W = 11
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire mcu_pkg::inst_t         inst,
    input  wire                         inst_valid,
    input  wire [1:0]                   level,
    input  wire mcu_pkg::data_t         rd_data_ctrl,
    input  wire mcu_pkg::data_t         rd_data_utab,
    input  wire                         done,
    output mcu_pkg::ctrl_state_t        state,
    output mcu_pkg::mem_req_t           ctrl_req,
    output mcu_pkg::mem_req_t           utab_req,
    output mcu_pkg::base_addrs_t        bases,
    output mcu_pkg::upc_t               upc_start,
    output logic [4:0][LOOP_W-1:0]      loop_cnt,
    output logic                        exec_start,
    output logic [1:0]                  wr_bank,
    output mcu_pkg::wr_src_t            wr_src,
    output logic                        macs_signal
);

    mcu_pkg::ctrl_state_t state_nxt;
    mcu_pkg::inst_t       inst_q;
    logic [2:0]           dec_cnt;
    logic                 dec_last;
    logic [LOOP_W-1:0]    row_cnt;

    assign dec_last = (state == mcu_pkg::ST_ID) && (dec_cnt == 3'd6);

    always_comb begin
        case (level)
            2'd1:    row_cnt = LOOP_W'(mcu_pkg::LVL1_LEN);
            2'd2:    row_cnt = LOOP_W'(mcu_pkg::LVL2_LEN);
            2'd3:    row_cnt = LOOP_W'(mcu_pkg::LVL3_LEN);
            default: row_cnt = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= mcu_pkg::ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mcu_pkg::ST_IDLE: state_nxt = mcu_pkg::ST_IF;
            mcu_pkg::ST_IF:   if (inst_valid) state_nxt = mcu_pkg::ST_ID;
            mcu_pkg::ST_ID:   if (dec_last) state_nxt = mcu_pkg::ST_EX;
            mcu_pkg::ST_EX:   if (done) state_nxt = mcu_pkg::ST_IDLE;
            default:          state_nxt = mcu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_q  <= '0;
            dec_cnt <= '0;
        end else begin
            if (state == mcu_pkg::ST_IF && inst_valid)
                inst_q <= inst;
            dec_cnt <= (state == mcu_pkg::ST_ID) ? dec_cnt + 3'd1 : 3'd0;
        end
    end

    // table reads, data returns one cycle after each address
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_req  <= '0;
            utab_req  <= '0;
            bases     <= '0;
            upc_start <= '0;
            wr_bank   <= '0;
        end else if (state == mcu_pkg::ST_ID) begin
            utab_req.wen <= 1'b0;   // micro-table read is a single cycle
            case (dec_cnt)
                3'd0: begin
                    ctrl_req <= '{addr: 12'(inst_q.idx_a), wen: 1'b1};
                    utab_req <= '{addr: 12'({inst_q.func, inst_q.opcode}), wen: 1'b1};
                end
                3'd1: ctrl_req.addr <= 12'(inst_q.idx_b);
                3'd2: begin
                    ctrl_req.addr <= 12'(inst_q.idx_c);
                    bases.a       <= rd_data_ctrl[13:0];
                    upc_start     <= rd_data_utab[7:0];
                end
                3'd3: begin
                    if (inst_q.opcode == mcu_pkg::OP_CLEAR)
                        bases.b <= {inst_q.b_bank, 1'b0, inst_q.idx_a, inst_q.idx_b,
                                    inst_q.idx_c};
                    else
                        bases.b <= rd_data_ctrl[13:0];
                end
                3'd4: begin
                    bases.c <= rd_data_ctrl[13:0];
                    bases.d <= {rd_data_ctrl[13], ~rd_data_ctrl[12], rd_data_ctrl[11:0]};
                end
                3'd5: begin
                    ctrl_req.wen <= 1'b0;
                    wr_bank      <= bases.d[13:12];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            loop_cnt    <= '0;
            wr_src      <= mcu_pkg::SRC_ZERO;
            macs_signal <= 1'b0;
            exec_start  <= 1'b0;
        end else begin
            exec_start <= dec_last;
            if (state == mcu_pkg::ST_ID && dec_cnt == 3'd0) begin
                loop_cnt    <= '0;
                wr_src      <= mcu_pkg::SRC_ZERO;
                macs_signal <= 1'b0;
                case (inst_q.opcode)
                    mcu_pkg::OP_CLEAR: begin
                        loop_cnt[0] <= LOOP_W'({inst_q.mode, inst_q.imm_lo});
                        loop_cnt[1] <= LOOP_W'(8);
                    end
                    mcu_pkg::OP_MAC: begin
                        loop_cnt[0] <= row_cnt;
                        loop_cnt[1] <= LOOP_W'(2);
                        loop_cnt[2] <= LOOP_W'(4);
                        wr_src      <= mcu_pkg::SRC_MACS;
                        macs_signal <= inst_q.mode;
                    end
                    mcu_pkg::OP_CODEC: begin
                        loop_cnt[0] <= LOOP_W'(16);
                        wr_src      <= inst_q.mode ? mcu_pkg::SRC_DECODE : mcu_pkg::SRC_ENCODE;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

    typedef logic [11:0] addr_t;    // word address inside one bank
    typedef logic [13:0] paddr_t;   // {bank, addr_t}
    typedef logic [63:0] data_t;
    typedef logic [7:0]  upc_t;

    typedef enum logic [2:0] {
        OP_CLEAR = 3'b000,
        OP_MAC   = 3'b100,
        OP_CODEC = 3'b110
    } opcode_t;

    // clear row count is {mode, imm_lo}
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] idx_a;      // control-table indices
        logic [3:0] idx_b;
        logic [3:0] idx_c;
        logic       mode;       // codec direction / mac sign
        logic [4:0] imm_lo;
        logic       spare_hi;
        logic       b_bank;
        logic [3:0] spare_lo;
        logic       func;
    } inst_t;

    typedef struct packed {
        logic       mem_wen;
        logic       codec_en;
        logic [3:0] stride;
        logic [3:0] ptr_clr;    // bit 0 is A, bit 3 is D
        logic [3:0] ptr_add;
        logic       mac_en;
        logic [2:0] loop_st;
        logic [2:0] loop_up;
        logic       done;
    } uinst_t;

    localparam int UINST_WIDTH = $bits(uinst_t);

    typedef enum logic [1:0] {
        SRC_ZERO,
        SRC_ENCODE,
        SRC_DECODE,
        SRC_MACS
    } wr_src_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IF,
        ST_ID,
        ST_EX
    } ctrl_state_t;

    typedef struct packed {
        paddr_t a;
        paddr_t b;
        paddr_t c;
        paddr_t d;
    } base_addrs_t;

    typedef struct packed {
        addr_t addr;
        logic  wen;
    } mem_req_t;

    localparam int LVL1_LEN = 1344;
    localparam int LVL2_LEN = 976;
    localparam int LVL3_LEN = 640;

endpackage

`default_nettype wire

/* src/mcu_top.sv */
`default_nettype none

module mcu_top #(
    parameter int LOOP_W = 11
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire mcu_pkg::inst_t         inst,
    input  wire                         inst_valid,
    input  wire [1:0]                   level,
    input  wire mcu_pkg::data_t [3:0]   mem_rd_data,
    input  wire mcu_pkg::data_t         macs_result,
    input  wire mcu_pkg::data_t         data_encode,
    input  wire mcu_pkg::data_t         data_decode,
    output mcu_pkg::mem_req_t [3:0]     mem_req,
    output mcu_pkg::data_t              mem_wr_data,
    output mcu_pkg::data_t              a_data,
    output mcu_pkg::data_t              b_data,
    output mcu_pkg::data_t              add_data,
    output logic                        macs_en,
    output logic                        macs_signal,
    output logic                        codec_en,
    output logic                        finish
);

    mcu_pkg::ctrl_state_t   state;
    mcu_pkg::mem_req_t      ctrl_req;
    mcu_pkg::mem_req_t      utab_req;
    mcu_pkg::base_addrs_t   bases;
    mcu_pkg::upc_t          upc_start;
    mcu_pkg::upc_t          upc;
    mcu_pkg::uinst_t        uinst;
    mcu_pkg::paddr_t [3:0]  ptrs;
    mcu_pkg::wr_src_t       wr_src;
    logic [4:0][LOOP_W-1:0] loop_cnt;
    logic                   exec_start;
    logic [1:0]             wr_bank;
    logic                   ex_active;
    logic                   mem_wen;

    // microcode only acts while executing
    assign ex_active = (state == mcu_pkg::ST_EX);
    assign mem_wen   = uinst.mem_wen & ex_active;
    assign macs_en   = uinst.mac_en & ex_active;
    assign codec_en  = uinst.codec_en & ex_active;
    assign finish    = uinst.done & ex_active;

    always_comb begin
        case (wr_src)
            mcu_pkg::SRC_ENCODE: mem_wr_data = data_encode;
            mcu_pkg::SRC_DECODE: mem_wr_data = data_decode;
            mcu_pkg::SRC_MACS:   mem_wr_data = macs_result;
            default:             mem_wr_data = '0;
        endcase
    end

    inst_decoder #(
        .LOOP_W(LOOP_W)
    ) inst_decoder_i (
        .clk(clk),
        .rstn(rstn),
        .inst(inst),
        .inst_valid(inst_valid),
        .level(level),
        .rd_data_ctrl(mem_rd_data[0]),
        .rd_data_utab(mem_rd_data[2]),
        .done(finish),
        .state(state),
        .ctrl_req(ctrl_req),
        .utab_req(utab_req),
        .bases(bases),
        .upc_start(upc_start),
        .loop_cnt(loop_cnt),
        .exec_start(exec_start),
        .wr_bank(wr_bank),
        .wr_src(wr_src),
        .macs_signal(macs_signal)
    );

    useq #(
        .LOOP_W(LOOP_W)
    ) useq_i (
        .clk(clk),
        .rstn(rstn),
        .exec_start(exec_start),
        .upc_start(upc_start),
        .loop_cnt(loop_cnt),
        .loop_up(uinst.loop_up),
        .loop_st(uinst.loop_st),
        .done(finish),
        .upc(upc)
    );

    urom urom_i (
        .clk(clk),
        .upc(upc),
        .uinst(uinst)
    );

    agu agu_i (
        .clk(clk),
        .rstn(rstn),
        .load(exec_start),
        .bases(bases),
        .ptr_add(uinst.ptr_add),
        .ptr_clr(uinst.ptr_clr),
        .stride(uinst.stride),
        .ptrs(ptrs)
    );

    mem_port_router mem_port_router_i (
        .ptrs(ptrs),
        .ctrl_req(ctrl_req),
        .utab_req(utab_req),
        .wr_bank(wr_bank),
        .mem_wen(mem_wen),
        .rd_data(mem_rd_data),
        .a_data(a_data),
        .b_data(b_data),
        .c_data(add_data),
        .mem_req(mem_req)
    );

endmodule

`default_nettype wire

/* src/mem_port_router.sv */
`default_nettype none

module mem_port_router (
    input  wire mcu_pkg::paddr_t [3:0]  ptrs,
    input  wire mcu_pkg::mem_req_t      ctrl_req,
    input  wire mcu_pkg::mem_req_t      utab_req,
    input  wire [1:0]                   wr_bank,
    input  wire                         mem_wen,
    input  wire mcu_pkg::data_t [3:0]   rd_data,
    output mcu_pkg::data_t              a_data,
    output mcu_pkg::data_t              b_data,
    output mcu_pkg::data_t              c_data,
    output mcu_pkg::mem_req_t [3:0]     mem_req
);

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            mem_req[p].wen = mem_wen && (wr_bank == 2'(p));
            if (wr_bank == 2'(p))
                mem_req[p].addr = ptrs[3][11:0];    // D owns the write port
            else if (ptrs[0][13:12] == 2'(p))
                mem_req[p].addr = ptrs[0][11:0];
            else if (ptrs[1][13:12] == 2'(p))
                mem_req[p].addr = ptrs[1][11:0];
            else if (ptrs[2][13:12] == 2'(p))
                mem_req[p].addr = ptrs[2][11:0];
            else
                mem_req[p].addr = '0;
        end
        // wen on an override only flags it active, decode never writes
        if (ctrl_req.wen)
            mem_req[0] = '{addr: ctrl_req.addr, wen: 1'b0};
        if (utab_req.wen)
            mem_req[2] = '{addr: utab_req.addr, wen: 1'b0};
    end

    assign a_data = rd_data[ptrs[0][13:12]];
    assign b_data = rd_data[ptrs[1][13:12]];
    assign c_data = rd_data[ptrs[2][13:12]];

endmodule

`default_nettype wire

/* src/ucode.hex */
// one 22-bit word per line, fields from the top:
// mem_wen codec_en stride ptr_clr ptr_add mac_en loop_st loop_up done
@00
000010  // clear, rows
000020  // 8 words per row
210800  // write zero, D += 1
000004
000000
000002
000000
000001
@10
000010  // mac, level rows
000020
000030
210F80  // mac write, all pointers step
000006
000000
000004
000000
000002
000000
000001
@20
000010  // codec, 16 words
310900
000002
000000
000001

/* src/urom.sv */
`default_nettype none

module urom (
    input  wire                 clk,
    input  wire mcu_pkg::upc_t  upc,
    output mcu_pkg::uinst_t     uinst
);

    logic [mcu_pkg::UINST_WIDTH-1:0] rom [256];

    initial begin
        for (int i = 0; i < 256; i++)
            rom[i] = '0;    // unused words do nothing
        $readmemh("src/ucode.hex", rom);
    end

    always_ff @(posedge clk)
        uinst <= rom[upc];

endmodule

`default_nettype wire

/* src/useq.sv */
`default_nettype none

module useq #(
    parameter int LOOP_W = 11
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         exec_start,
    input  wire mcu_pkg::upc_t          upc_start,
    input  wire [4:0][LOOP_W-1:0]       loop_cnt,
    input  wire [2:0]                   loop_up,
    input  wire [2:0]                   loop_st,
    input  wire                         done,
    output mcu_pkg::upc_t               upc
);

    localparam mcu_pkg::upc_t UPC_IDLE = 8'hff;   // all-zero word, parked here

    mcu_pkg::upc_t     body [5];
    logic [LOOP_W-1:0] cnt  [5];
    logic [2:0]        st_idx;
    logic [2:0]        up_idx;
    logic              up_hit;

    assign st_idx = loop_st - 3'd1;
    assign up_idx = loop_up - 3'd1;
    assign up_hit = (loop_up inside {[3'd1:3'd5]}) && (cnt[up_idx] > LOOP_W'(1));

    // upc already points past the word on uinst, so that is the body start
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            upc <= UPC_IDLE;
            for (int k = 0; k < 5; k++) begin
                body[k] <= '0;
                cnt[k]  <= '0;
            end
        end else if (exec_start) begin
            upc <= upc_start;
        end else begin
            if (loop_st inside {[3'd1:3'd5]}) begin
                body[st_idx] <= upc;
                cnt[st_idx]  <= loop_cnt[st_idx];
            end
            if (up_hit)
                cnt[up_idx] <= cnt[up_idx] - LOOP_W'(1);
            if (done)
                upc <= UPC_IDLE;
            else if (up_hit)
                upc <= body[up_idx];
            else if (upc != UPC_IDLE)
                upc <= upc + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
src/mcu_pkg.sv
src/inst_decoder.sv
src/useq.sv
src/urom.sv
src/agu.sv
src/mem_port_router.sv
src/mcu_top.sv
dv/tb_top.sv
